/* common/dtm_pkg.sv */
`default_nettype none

package dtm_pkg;

    // widths fixed by the riscv debug spec
    localparam int IR_WIDTH     = 5;
    localparam int DMI_ABITS    = 10;
    localparam int DMI_DBITS    = 32;
    localparam int DMI_WIDTH    = DMI_ABITS + DMI_DBITS + 2;
    localparam int IDCODE_WIDTH = 32;

    // instructions decoded by the dtm, anything else acts as bypass
    typedef enum logic [IR_WIDTH-1:0] {
        INSTR_IDCODE = 5'b00001,
        INSTR_DMI    = 5'b10001,
        INSTR_BYPASS = 5'b11111
    } ir_instr_e;

    // outgoing dmi op field
    typedef enum logic [1:0] {
        DMI_OP_NOP      = 2'd0,
        DMI_OP_READ     = 2'd1,
        DMI_OP_WRITE    = 2'd2,
        DMI_OP_RESERVED = 2'd3
    } dmi_op_e;

    // the sixteen tap states
    typedef enum logic [3:0] {
        TAP_TEST_LOGIC_RESET = 4'd0,
        TAP_RUN_TEST_IDLE    = 4'd1,
        TAP_SELECT_DR_SCAN   = 4'd2,
        TAP_CAPTURE_DR       = 4'd3,
        TAP_SHIFT_DR         = 4'd4,
        TAP_EXIT1_DR         = 4'd5,
        TAP_PAUSE_DR         = 4'd6,
        TAP_EXIT2_DR         = 4'd7,
        TAP_UPDATE_DR        = 4'd8,
        TAP_SELECT_IR_SCAN   = 4'd9,
        TAP_CAPTURE_IR       = 4'd10,
        TAP_SHIFT_IR         = 4'd11,
        TAP_EXIT1_IR         = 4'd12,
        TAP_PAUSE_IR         = 4'd13,
        TAP_EXIT2_IR         = 4'd14,
        TAP_UPDATE_IR        = 4'd15
    } tap_state_e;

    // address on top, op in the two lsbs
    typedef struct packed {
        logic [DMI_ABITS-1:0] addr;
        logic [DMI_DBITS-1:0] data;
        dmi_op_e              op;
    } dmi_word_t;

    // jtag clock edges and pin levels, all in the clk domain
    typedef struct packed {
        logic tck_rise;
        logic tck_fall;
        logic tms;
        logic tdi;
    } tck_strobe_t;

    // one-clk transition strobes from the tap controller
    typedef struct packed {
        logic reset_tap;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic select_dr;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic tdo_fall_ir;
        logic tdo_fall_dr;
    } tap_ctrl_t;

endpackage

`default_nettype wire

/* logic/tck_sync.sv */
`default_nettype none
`timescale 1ns/1ps

module tck_sync (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    input  wire                  jtag_clk_i,
    input  wire                  jtag_tms_i,
    input  wire                  jtag_tdi_i,
    output dtm_pkg::tck_strobe_t tck_o
);

    // bit order {clk, tms, tdi}
    logic [2:0] pin_meta;
    logic [2:0] pin_sync;
    // last synchronized jtag clock level
    logic       clk_prev;

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            pin_meta <= '0;
            pin_sync <= '0;
            clk_prev <= 1'b0;
            tck_o    <= '0;
        end
        else
        begin
            // two flop synchronizer on all three pins
            pin_meta <= {jtag_clk_i, jtag_tms_i, jtag_tdi_i};
            pin_sync <= pin_meta;
            clk_prev <= pin_sync[2];
            // edge strobes, registered once more
            tck_o.tck_rise <= pin_sync[2] & ~clk_prev;
            tck_o.tck_fall <= ~pin_sync[2] & clk_prev;
            // tms and tdi taken at the same point as the clock
            tck_o.tms <= pin_sync[1];
            tck_o.tdi <= pin_sync[0];
        end
    end

endmodule

`default_nettype wire

/* tap/tap_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

module tap_fsm (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    input  dtm_pkg::tck_strobe_t tck_i,
    output dtm_pkg::tap_ctrl_t   ctrl_o
);

    import dtm_pkg::*;

    tap_state_e state_q;
    tap_state_e state_next;
    // high on a rise that moves to another state
    logic       entering;

    // standard tms graph
    always_comb
    begin
        case (state_q)
            TAP_TEST_LOGIC_RESET: state_next = tck_i.tms ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
            TAP_RUN_TEST_IDLE:    state_next = tck_i.tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            TAP_SELECT_DR_SCAN:   state_next = tck_i.tms ? TAP_SELECT_IR_SCAN : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR:       state_next = tck_i.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR:         state_next = tck_i.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR:         state_next = tck_i.tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:         state_next = tck_i.tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR:         state_next = tck_i.tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:        state_next = tck_i.tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            TAP_SELECT_IR_SCAN:   state_next = tck_i.tms ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR:       state_next = tck_i.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR:         state_next = tck_i.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR:         state_next = tck_i.tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:         state_next = tck_i.tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR:         state_next = tck_i.tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:        state_next = tck_i.tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            default:              state_next = TAP_TEST_LOGIC_RESET;
        endcase
    end

    // state only moves on a jtag clock rise
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            state_q <= TAP_TEST_LOGIC_RESET;
        else if (tck_i.tck_rise)
            state_q <= state_next;
    end

    assign entering = tck_i.tck_rise && (state_next != state_q);

    // strobes live in the same cycle as the rise that causes them
    always_comb
    begin
        ctrl_o = '0;
        ctrl_o.reset_tap  = entering && (state_next == TAP_TEST_LOGIC_RESET);
        ctrl_o.select_dr  = entering && (state_next == TAP_SELECT_DR_SCAN);
        ctrl_o.capture_ir = entering && (state_next == TAP_CAPTURE_IR);
        ctrl_o.update_ir  = entering && (state_next == TAP_UPDATE_IR);
        ctrl_o.capture_dr = entering && (state_next == TAP_CAPTURE_DR);
        ctrl_o.update_dr  = entering && (state_next == TAP_UPDATE_DR);
        // shift on every rise in shift, the exit rise too
        ctrl_o.shift_ir = tck_i.tck_rise && (state_q == TAP_SHIFT_IR);
        ctrl_o.shift_dr = tck_i.tck_rise && (state_q == TAP_SHIFT_DR);
        // tdo moves on the falling jtag clock
        ctrl_o.tdo_fall_ir = tck_i.tck_fall && (state_q == TAP_SHIFT_IR);
        ctrl_o.tdo_fall_dr = tck_i.tck_fall && (state_q == TAP_SHIFT_DR);
    end

endmodule

`default_nettype wire

/* tap/tap_ir.sv */
`default_nettype none
`timescale 1ns/1ps

module tap_ir (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    input  dtm_pkg::tck_strobe_t tck_i,
    input  dtm_pkg::tap_ctrl_t   ctrl_i,
    output dtm_pkg::ir_instr_e   ir_o,
    output logic                 ir_lsb_o
);

    import dtm_pkg::*;

    logic [IR_WIDTH-1:0] ir_shift;

    // capture reloads the current instruction, shift goes lsb first
    always_ff @(posedge clk_i)
    begin
        if (ctrl_i.capture_ir)
            ir_shift <= ir_o;
        else if (ctrl_i.shift_ir)
            ir_shift <= {tck_i.tdi, ir_shift[IR_WIDTH-1:1]};
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i || ctrl_i.reset_tap)
            ir_o <= INSTR_IDCODE;
        else if (ctrl_i.update_ir)
        begin
            case (ir_shift)
                INSTR_IDCODE,
                INSTR_DMI,
                INSTR_BYPASS:
                    ir_o <= ir_instr_e'(ir_shift);
                // unknown codes fall back to bypass
                default:
                    ir_o <= INSTR_BYPASS;
            endcase
        end
    end

    // bit that goes out on tdo next
    assign ir_lsb_o = ir_shift[0];

endmodule

`default_nettype wire

/* tap/tap_dr.sv */
`default_nettype none
`timescale 1ns/1ps

module tap_dr #(
    parameter logic [dtm_pkg::IDCODE_WIDTH-1:0] IDCODE_VALUE = 32'h12345678
) (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    input  dtm_pkg::tck_strobe_t tck_i,
    input  dtm_pkg::tap_ctrl_t   ctrl_i,
    input  dtm_pkg::ir_instr_e   ir_i,
    input  wire                  ir_lsb_i,
    input  dtm_pkg::dmi_word_t   dmi_held_i,
    output logic                 dmi_update_o,
    output dtm_pkg::dmi_word_t   dmi_word_o,
    output logic                 jtag_tdo_o
);

    import dtm_pkg::*;

    logic [IDCODE_WIDTH-1:0] idcode_shift;
    logic                    bypass_shift;
    dmi_word_t               dmi_shift;
    // lsb of whichever dr the instruction picks
    logic                    dr_lsb;

    // only the selected register captures or shifts
    always_ff @(posedge clk_i)
    begin
        case (ir_i)
            INSTR_IDCODE:
            begin
                if (ctrl_i.capture_dr)
                    idcode_shift <= IDCODE_VALUE;
                else if (ctrl_i.shift_dr)
                    idcode_shift <= {tck_i.tdi, idcode_shift[IDCODE_WIDTH-1:1]};
            end
            INSTR_DMI:
            begin
                // capture returns the last updated word
                if (ctrl_i.capture_dr)
                    dmi_shift <= dmi_held_i;
                else if (ctrl_i.shift_dr)
                    dmi_shift <= dmi_word_t'({tck_i.tdi, dmi_shift[DMI_WIDTH-1:1]});
            end
            default:
            begin
                // bypass, one bit, captures zero
                if (ctrl_i.capture_dr)
                    bypass_shift <= 1'b0;
                else if (ctrl_i.shift_dr)
                    bypass_shift <= tck_i.tdi;
            end
        endcase
    end

    always_comb
    begin
        case (ir_i)
            INSTR_IDCODE: dr_lsb = idcode_shift[0];
            INSTR_DMI:    dr_lsb = dmi_shift[0];
            default:      dr_lsb = bypass_shift;
        endcase
    end

    // update pulse towards the request block
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            dmi_update_o <= 1'b0;
        else
            dmi_update_o <= ctrl_i.update_dr && (ir_i == INSTR_DMI);
    end

    assign dmi_word_o = dmi_shift;

    // tdo changes one clk after the falling strobe, holds otherwise
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            jtag_tdo_o <= 1'b0;
        else if (ctrl_i.tdo_fall_ir)
            jtag_tdo_o <= ir_lsb_i;
        else if (ctrl_i.tdo_fall_dr)
            jtag_tdo_o <= dr_lsb;
    end

endmodule

`default_nettype wire

/* logic/dmi_request.sv */
`default_nettype none
`timescale 1ns/1ps

module dmi_request (
    input  wire                clk_i,
    input  wire                rst_n_i,
    input  dtm_pkg::tap_ctrl_t ctrl_i,
    input  wire                dmi_update_i,
    input  dtm_pkg::dmi_word_t dmi_word_i,
    output dtm_pkg::dmi_word_t dmi_held_o,
    output logic               start_read_o,
    output logic               start_write_o
);

    import dtm_pkg::*;

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            dmi_held_o    <= '0;
            start_read_o  <= 1'b0;
            start_write_o <= 1'b0;
        end
        else if (ctrl_i.select_dr || ctrl_i.reset_tap)
        begin
            // a new scan or a tap reset drops the request
            start_read_o  <= 1'b0;
            start_write_o <= 1'b0;
        end
        else if (dmi_update_i)
        begin
            dmi_held_o    <= dmi_word_i;
            // nop and reserved leave both low
            start_read_o  <= (dmi_word_i.op == DMI_OP_READ);
            start_write_o <= (dmi_word_i.op == DMI_OP_WRITE);
        end
    end

endmodule

`default_nettype wire

/* logic/jtag_dtm_top.sv */
`default_nettype none
`timescale 1ns/1ps

module jtag_dtm_top #(
    parameter logic [dtm_pkg::IDCODE_WIDTH-1:0] IDCODE_VALUE = 32'h12345678
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            jtag_clk_i,
    input  wire                            jtag_tms_i,
    input  wire                            jtag_tdi_i,
    output logic                           jtag_tdo_o,
    output logic                           start_read_o,
    output logic                           start_write_o,
    output logic [dtm_pkg::DMI_ABITS-1:0]  dmi_addr_o,
    output logic [dtm_pkg::DMI_DBITS-1:0]  dmi_wdata_o
);

    import dtm_pkg::*;

    tck_strobe_t tck;
    tap_ctrl_t   ctrl;
    ir_instr_e   ir;
    logic        ir_lsb;
    logic        dmi_update;
    dmi_word_t   dmi_word;
    dmi_word_t   dmi_held;

    // jtag pins into the clk domain
    tck_sync u_tck_sync (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .jtag_clk_i (jtag_clk_i),
        .jtag_tms_i (jtag_tms_i),
        .jtag_tdi_i (jtag_tdi_i),
        .tck_o      (tck)
    );

    tap_fsm u_tap_fsm (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .tck_i   (tck),
        .ctrl_o  (ctrl)
    );

    tap_ir u_tap_ir (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .tck_i    (tck),
        .ctrl_i   (ctrl),
        .ir_o     (ir),
        .ir_lsb_o (ir_lsb)
    );

    tap_dr #(
        .IDCODE_VALUE (IDCODE_VALUE)
    ) u_tap_dr (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .tck_i        (tck),
        .ctrl_i       (ctrl),
        .ir_i         (ir),
        .ir_lsb_i     (ir_lsb),
        .dmi_held_i   (dmi_held),
        .dmi_update_o (dmi_update),
        .dmi_word_o   (dmi_word),
        .jtag_tdo_o   (jtag_tdo_o)
    );

    // start levels for the bus master
    dmi_request u_dmi_request (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .ctrl_i        (ctrl),
        .dmi_update_i  (dmi_update),
        .dmi_word_i    (dmi_word),
        .dmi_held_o    (dmi_held),
        .start_read_o  (start_read_o),
        .start_write_o (start_write_o)
    );

    assign dmi_addr_o  = dmi_held.addr;
    assign dmi_wdata_o = dmi_held.data;

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 10 ns period
    initial
    begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset held for 8 cycles, released just after an edge
    initial
    begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* test/jtag_dtm_props.sv */
`default_nettype none
`timescale 1ns/1ps

module jtag_dtm_props (
    input wire                           clk_i,
    input wire                           rst_n_i,
    input wire                           start_read_i,
    input wire                           start_write_i,
    input wire [dtm_pkg::DMI_ABITS-1:0]  dmi_addr_i,
    input wire [dtm_pkg::DMI_DBITS-1:0]  dmi_wdata_i
);

    // failure counts, one per property
    int unsigned excl_fail_count   = 0;
    int unsigned reset_fail_count  = 0;
    int unsigned stable_fail_count = 0;

    // read and write never requested together
    start_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(start_read_i && start_write_i)
    )
    else
    begin
        $error("start_read and start_write high together");
        excl_fail_count++;
    end

    // synchronous reset, so levels are checked one clk later
    start_low_in_reset: assert property (
        @(posedge clk_i)
        !rst_n_i |=> (!start_read_i && !start_write_i)
    )
    else
    begin
        $error("start level high during reset");
        reset_fail_count++;
    end

    // bus master samples address and data while a level is up
    request_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (start_read_i || start_write_i) |=> ($stable(dmi_addr_i) && $stable(dmi_wdata_i))
    )
    else
    begin
        $error("dmi address or data moved while a start level was high");
        stable_fail_count++;
    end

endmodule

bind jtag_dtm_top jtag_dtm_props u_props (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .start_read_i  (start_read_o),
    .start_write_i (start_write_o),
    .dmi_addr_i    (dmi_addr_o),
    .dmi_wdata_i   (dmi_wdata_o)
);

`default_nettype wire

/* test/jtag_dtm_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module jtag_dtm_tb;

    localparam logic [31:0] IDCODE_VALUE = 32'h1e5b7a3d;
    localparam logic [31:0] RANDOM_SEED  = 32'h7a4ca480;
    // jtag half period in clk cycles
    localparam int          HALF_PERIOD  = 8;
    localparam int          WAIT_LIMIT   = 40;
    localparam int          DMI_BITS     = 44;
    localparam logic [4:0]  IR_IDCODE    = 5'b00001;
    localparam logic [4:0]  IR_DMI       = 5'b10001;
    localparam logic [4:0]  IR_BYPASS    = 5'b11111;
    localparam logic [1:0]  OP_NOP       = 2'd0;
    localparam logic [1:0]  OP_READ      = 2'd1;
    localparam logic [1:0]  OP_WRITE     = 2'd2;

    logic        clk;
    logic        rst_n;
    logic        jtag_clk;
    logic        jtag_tms;
    logic        jtag_tdi;
    logic        jtag_tdo;
    logic        start_read;
    logic        start_write;
    logic [9:0]  dmi_addr;
    logic [31:0] dmi_wdata;
    logic [63:0] dout;
    logic [63:0] pattern;
    logic [63:0] write_word;
    logic [63:0] read_word;
    logic [63:0] nop_word;
    logic        tdo_bit;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    jtag_dtm_top #(
        .IDCODE_VALUE (IDCODE_VALUE)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .jtag_clk_i    (jtag_clk),
        .jtag_tms_i    (jtag_tms),
        .jtag_tdi_i    (jtag_tdi),
        .jtag_tdo_o    (jtag_tdo),
        .start_read_o  (start_read),
        .start_write_o (start_write),
        .dmi_addr_o    (dmi_addr),
        .dmi_wdata_o   (dmi_wdata)
    );

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_value(input string test_name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else
        begin
            $display("ERROR %s: expected %0h, actual %0h", test_name, expected, actual);
            stop_run();
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT)
            begin
                $display("reset was never released");
                stop_run();
            end
        end
        @(posedge clk);
        #1;
    endtask

    // poll the start levels, the pipeline is a few clk deep
    task automatic wait_start(input string test_name, input logic exp_read,
                              input logic exp_write);
        int cycles;
        cycles = 0;
        while ({start_read, start_write} !== {exp_read, exp_write})
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT)
            begin
                $display("%s: start levels never reached read %0b write %0b",
                         test_name, exp_read, exp_write);
                stop_run();
            end
        end
    endtask

    // one jtag clock, entered and left 1 ns after a clk edge with jtag_clk low
    task automatic step_tck(input logic tms, input logic tdi, output logic tdo);
        jtag_tms = tms;
        jtag_tdi = tdi;
        repeat (HALF_PERIOD) @(posedge clk);
        #1;
        // tdo taken just before the rising edge
        tdo = jtag_tdo;
        jtag_clk = 1'b1;
        repeat (HALF_PERIOD) @(posedge clk);
        #1;
        jtag_clk = 1'b0;
    endtask

    // lsb first, tms high on the last bit leaves shift
    task automatic shift_bits(input int nbits, input logic [63:0] din,
                              output logic [63:0] dout_o);
        int   i;
        logic bit_out;
        dout_o = '0;
        for (i = 0; i < nbits; i++)
        begin
            step_tck(i == nbits - 1, din[i], bit_out);
            dout_o[i] = bit_out;
        end
    endtask

    // from select_dr through update back to idle
    task automatic dr_from_select(input int nbits, input logic [63:0] din,
                                  output logic [63:0] dout_o);
        logic unused;
        step_tck(1'b0, 1'b0, unused);
        step_tck(1'b0, 1'b0, unused);
        shift_bits(nbits, din, dout_o);
        step_tck(1'b1, 1'b0, unused);
        step_tck(1'b0, 1'b0, unused);
    endtask

    task automatic scan_dr(input int nbits, input logic [63:0] din,
                           output logic [63:0] dout_o);
        logic unused;
        step_tck(1'b1, 1'b0, unused);
        dr_from_select(nbits, din, dout_o);
    endtask

    // idle to select_dr, select_ir, capture, shift, update, idle
    task automatic scan_ir(input logic [4:0] instr, output logic [63:0] dout_o);
        logic unused;
        step_tck(1'b1, 1'b0, unused);
        step_tck(1'b1, 1'b0, unused);
        step_tck(1'b0, 1'b0, unused);
        step_tck(1'b0, 1'b0, unused);
        shift_bits(5, {59'b0, instr}, dout_o);
        step_tck(1'b1, 1'b0, unused);
        step_tck(1'b0, 1'b0, unused);
    endtask

    // address on top, op in the two lsbs
    function automatic logic [63:0] make_word(input logic [9:0] addr,
                                              input logic [31:0] data,
                                              input logic [1:0] op);
        return {20'b0, addr, data, op};
    endfunction

    initial
    begin
        void'($urandom(RANDOM_SEED));
        jtag_clk = 1'b0;
        jtag_tms = 1'b1;
        jtag_tdi = 1'b0;
        wait_reset_release();

        // idcode after reset
        check_value("reset_start", 2'b00, {start_read, start_write});
        check_value("reset_tdo", 1'b0, jtag_tdo);
        check_value("reset_addr", 10'd0, dmi_addr);
        check_value("reset_wdata", 32'd0, dmi_wdata);
        step_tck(1'b0, 1'b0, tdo_bit);
        scan_dr(32, '0, dout);
        check_value("idcode", IDCODE_VALUE, dout);

        // ir capture returns the current instruction
        scan_ir(IR_DMI, dout);
        check_value("ir_capture_idcode", IR_IDCODE, dout);
        scan_ir(IR_DMI, dout);
        check_value("ir_capture_dmi", IR_DMI, dout);

        // bypass delays the pattern by one bit behind a zero
        scan_ir(IR_BYPASS, dout);
        pattern = {48'b0, 16'($urandom)};
        scan_dr(16, pattern, dout);
        check_value("bypass", {pattern[14:0], 1'b0}, dout);

        // five tms ones reach test logic reset
        repeat (5) step_tck(1'b1, 1'b0, tdo_bit);
        step_tck(1'b0, 1'b0, tdo_bit);
        scan_dr(32, '0, dout);
        check_value("idcode_after_tap_reset", IDCODE_VALUE, dout);

        // dmi write
        scan_ir(IR_DMI, dout);
        write_word = make_word(10'($urandom), $urandom, OP_WRITE);
        scan_dr(DMI_BITS, write_word, dout);
        wait_start("dmi_write", 1'b0, 1'b1);
        check_value("dmi_write_addr", write_word[43:34], dmi_addr);
        check_value("dmi_write_data", write_word[33:2], dmi_wdata);

        // select_dr drops the level
        step_tck(1'b1, 1'b0, tdo_bit);
        wait_start("dmi_select_clear", 1'b0, 1'b0);

        // dmi read, capture hands back the write word
        read_word = make_word(10'($urandom), $urandom, OP_READ);
        dr_from_select(DMI_BITS, read_word, dout);
        check_value("dmi_capture_write", write_word, dout);
        wait_start("dmi_read", 1'b1, 1'b0);
        check_value("dmi_read_addr", read_word[43:34], dmi_addr);
        check_value("dmi_read_data", read_word[33:2], dmi_wdata);

        // nop leaves both levels low
        nop_word = make_word(10'($urandom), $urandom, OP_NOP);
        scan_dr(DMI_BITS, nop_word, dout);
        check_value("dmi_capture_read", read_word, dout);
        wait_start("dmi_nop", 1'b0, 1'b0);
        check_value("dmi_nop_addr", nop_word[43:34], dmi_addr);
        check_value("dmi_nop_data", nop_word[33:2], dmi_wdata);

        // capture of the last updated word
        scan_dr(DMI_BITS, '0, dout);
        check_value("dmi_capture_nop", nop_word, dout);

        if (dut_i.u_props.excl_fail_count + dut_i.u_props.reset_fail_count
            + dut_i.u_props.stable_fail_count == 0)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
        begin
            $display("a concurrent property failed during the run");
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* project.f */
common/dtm_pkg.sv
logic/tck_sync.sv
tap/tap_fsm.sv
tap/tap_ir.sv
tap/tap_dr.sv
logic/dmi_request.sv
logic/jtag_dtm_top.sv
test/tb_clock_gen.sv
test/jtag_dtm_props.sv
test/jtag_dtm_tb.sv
